/* src/periph_pkg.sv */
package periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and types
    //////////////////////////////////////////////////////////////////////
    localparam int unsigned APB_ADDR_W = 32;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned NGPIO      = 32;
    localparam int unsigned FC_EVENT_W = 32;
    localparam int unsigned JTAG_REG_W = 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [NGPIO-1:0]      gpio_vec_t;  // one bit per pin
    typedef logic [FC_EVENT_W-1:0] fc_event_t;
    typedef logic [JTAG_REG_W-1:0] jtag_reg_t;

    //////////////////////////////////////////////////////////////////////
    // address map, 16 slots of 4 KiB in paddr[15:12]
    //////////////////////////////////////////////////////////////////////
    localparam int unsigned SLOT_LSB = 12;
    localparam int unsigned SLOT_W   = 4;

    typedef logic [SLOT_W-1:0]   slot_t;
    typedef logic [SLOT_LSB-1:0] reg_off_t; // byte offset inside a slot

    localparam slot_t SLOT_GPIO     = 4'd1;
    localparam slot_t SLOT_SOC_CTRL = 4'd4;

    // gpio offsets
    localparam reg_off_t GPIO_DIR_OFF     = 12'h000; // rw
    localparam reg_off_t GPIO_IN_OFF      = 12'h004; // ro, synced pins
    localparam reg_off_t GPIO_OUT_OFF     = 12'h008; // rw
    localparam reg_off_t GPIO_INTEN_OFF   = 12'h00C; // rw, rising edge mask
    localparam reg_off_t GPIO_INTSTAT_OFF = 12'h010; // read clears

    // soc control offsets
    localparam reg_off_t  CTRL_BOOTADDR_OFF = 12'h004;
    localparam reg_off_t  CTRL_FETCHEN_OFF  = 12'h008; // bit 0 only
    localparam reg_off_t  CTRL_JTAG_OFF     = 12'h00C; // {jtag_in, stored}
    localparam apb_data_t BOOT_ADDR_RST     = 32'h1C00_8080;

    // fc event vector positions, everything else tied low
    localparam int unsigned EVT_DMA_PE  = 8;
    localparam int unsigned EVT_DMA_IRQ = 9;
    localparam int unsigned EVT_PF      = 12;
    localparam int unsigned EVT_REF_CLK = 14;
    localparam int unsigned EVT_GPIO    = 15;

endpackage

/* src/apb_if.sv */
interface apb_if
    import periph_pkg::*;
();

    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;   // carries the in-slot offset only
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // request side, driven by the address decoder
    modport decoder (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    // register block side
    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* src/periph_bus_decoder.sv */
module periph_bus_decoder
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    // external apb
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    // completer side
    apb_if.decoder    gpio_bus,
    apb_if.decoder    ctrl_bus
);

    slot_t     slot;
    apb_addr_t offset; // slot bits stripped

    assign slot   = paddr_i[SLOT_LSB +: SLOT_W];
    assign offset = apb_addr_t'(paddr_i[SLOT_LSB-1:0]);

    //////////////////////////////////////////////////////////////////////
    // request steering
    //////////////////////////////////////////////////////////////////////
    assign gpio_bus.psel    = psel_i && (slot == SLOT_GPIO);
    assign gpio_bus.penable = penable_i;
    assign gpio_bus.pwrite  = pwrite_i;
    assign gpio_bus.paddr   = offset;
    assign gpio_bus.pwdata  = pwdata_i;

    assign ctrl_bus.psel    = psel_i && (slot == SLOT_SOC_CTRL);
    assign ctrl_bus.penable = penable_i;
    assign ctrl_bus.pwrite  = pwrite_i;
    assign ctrl_bus.paddr   = offset;
    assign ctrl_bus.pwdata  = pwdata_i;

    //////////////////////////////////////////////////////////////////////
    // response mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        // unmapped slot, answered here with an error and no data
        prdata_o  = '0;
        pready_o  = psel_i;
        pslverr_o = psel_i & penable_i;
        case (slot)
            SLOT_GPIO: begin
                prdata_o  = gpio_bus.prdata;
                pready_o  = psel_i & gpio_bus.pready;
                pslverr_o = psel_i & gpio_bus.pslverr;
            end
            SLOT_SOC_CTRL: begin
                prdata_o  = ctrl_bus.prdata;
                pready_o  = psel_i & ctrl_bus.pready;
                pslverr_o = psel_i & ctrl_bus.pslverr;
            end
            default: ;
        endcase
    end

    a_onehot_psel : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({gpio_bus.psel, ctrl_bus.psel}))
        else $error("more than one completer selected");

    a_pready_psel : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pready_o |-> psel_i)
        else $error("pready without psel");

endmodule

/* src/gpio_regs.sv */
module gpio_regs
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    apb_if.completer   bus,
    input  gpio_vec_t  gpio_in_i,
    output gpio_vec_t  gpio_out_o,
    output gpio_vec_t  gpio_dir_o,
    output logic       gpio_event_o
);

    reg_off_t  off;
    logic      wr_en;
    logic      rd_en;
    logic      off_ok;

    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t inten_q;
    gpio_vec_t intstat_q;
    gpio_vec_t sync1_q;  // first sync stage, may go metastable
    gpio_vec_t sync2_q;  // IN register value
    gpio_vec_t sync3_q;  // previous IN, for edge detection
    gpio_vec_t rise_masked;
    logic      event_q;

    assign off   = bus.paddr[SLOT_LSB-1:0];
    assign wr_en = bus.psel & bus.penable & bus.pwrite;
    assign rd_en = bus.psel & bus.penable & ~bus.pwrite;

    //////////////////////////////////////////////////////////////////////
    // input synchronizer and edge detect
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync1_q <= '0;
            sync2_q <= '0;
            sync3_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            sync3_q <= sync2_q;
        end
    end

    assign rise_masked = sync2_q & ~sync3_q & inten_q; // only enabled pins

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dir_q     <= '0;
            out_q     <= '0;
            inten_q   <= '0;
            intstat_q <= '0;
            event_q   <= 1'b0;
        end else begin
            if (wr_en && off == GPIO_DIR_OFF)   dir_q   <= bus.pwdata;
            if (wr_en && off == GPIO_OUT_OFF)   out_q   <= bus.pwdata;
            if (wr_en && off == GPIO_INTEN_OFF) inten_q <= bus.pwdata;
            // clearing read loses nothing, a new edge still lands
            if (rd_en && off == GPIO_INTSTAT_OFF)
                intstat_q <= rise_masked;
            else
                intstat_q <= intstat_q | rise_masked;
            event_q <= |rise_masked;  // one cycle per edge batch
        end
    end

    //////////////////////////////////////////////////////////////////////
    // apb response, zero wait states
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        bus.prdata = '0;
        off_ok     = 1'b1;
        case (off)
            GPIO_DIR_OFF:     bus.prdata = dir_q;
            GPIO_IN_OFF:      bus.prdata = sync2_q;
            GPIO_OUT_OFF:     bus.prdata = out_q;
            GPIO_INTEN_OFF:   bus.prdata = inten_q;
            GPIO_INTSTAT_OFF: bus.prdata = intstat_q;
            default:          off_ok     = 1'b0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = bus.psel & bus.penable & ~off_ok;

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = event_q;

    // a pulse needs an enabled pin one cycle before
    a_event_inten : assert property (@(posedge clk_i) disable iff (!rst_ni)
        gpio_event_o |-> $past(inten_q != '0))
        else $error("gpio event with interrupts masked");

endmodule

/* src/soc_ctrl_regs.sv */
module soc_ctrl_regs
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    apb_if.completer  bus,
    input  jtag_reg_t soc_jtag_reg_i,
    output jtag_reg_t soc_jtag_reg_o,
    output apb_data_t fc_bootaddr_o,
    output logic      fc_fetchen_o
);

    reg_off_t  off;
    logic      wr_en;
    logic      off_ok;
    apb_data_t bootaddr_q;
    logic      fetchen_q;
    jtag_reg_t jtag_q;

    assign off   = bus.paddr[SLOT_LSB-1:0];
    assign wr_en = bus.psel & bus.penable & bus.pwrite;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bootaddr_q <= BOOT_ADDR_RST;
            fetchen_q  <= 1'b0;       // core held until sw/debugger starts it
            jtag_q     <= '0;
        end else if (wr_en) begin
            case (off)
                CTRL_BOOTADDR_OFF: bootaddr_q <= bus.pwdata;
                CTRL_FETCHEN_OFF:  fetchen_q  <= bus.pwdata[0];
                CTRL_JTAG_OFF:     jtag_q     <= bus.pwdata[JTAG_REG_W-1:0];
                default: ;
            endcase
        end
    end

    // read mux, jtag offset shows both directions side by side
    always_comb begin
        bus.prdata = '0;
        off_ok     = 1'b1;
        case (off)
            CTRL_BOOTADDR_OFF: bus.prdata = bootaddr_q;
            CTRL_FETCHEN_OFF:  bus.prdata = apb_data_t'(fetchen_q);
            CTRL_JTAG_OFF:     bus.prdata = apb_data_t'({soc_jtag_reg_i, jtag_q});
            default:           off_ok     = 1'b0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = bus.psel & bus.penable & ~off_ok;

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign soc_jtag_reg_o = jtag_q;

    a_no_wait : assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus.penable |-> bus.pready)
        else $error("soc ctrl inserted a wait state");

endmodule

/* src/ref_clk_edge_detect.sv */
module ref_clk_edge_detect (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    logic [2:0] sync_q;  // [1:0] synchronizer, [2] history
    logic       rise_q;
    logic       fall_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[1:0], slow_clk_i};
            rise_q <= sync_q[1] & ~sync_q[2];   // lands on the 3rd edge
            fall_q <= ~sync_q[1] & sync_q[2];
        end
    end

    assign rise_o = rise_q;
    assign fall_o = fall_q;

    a_rise_fall_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(rise_o && fall_o))
        else $error("rise and fall pulses together");

endmodule

/* src/soc_periph_top.sv */
module soc_periph_top
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      slow_clk_i,
    // apb completer port
    input  logic      apb_psel_i,
    input  logic      apb_penable_i,
    input  logic      apb_pwrite_i,
    input  apb_addr_t apb_paddr_i,
    input  apb_data_t apb_pwdata_i,
    output apb_data_t apb_prdata_o,
    output logic      apb_pready_o,
    output logic      apb_pslverr_o,
    // gpio pins
    input  gpio_vec_t gpio_in_i,
    output gpio_vec_t gpio_out_o,
    output gpio_vec_t gpio_dir_o,
    // fc boot control
    output apb_data_t fc_bootaddr_o,
    output logic      fc_fetchen_o,
    input  jtag_reg_t soc_jtag_reg_i,
    output jtag_reg_t soc_jtag_reg_o,
    // event sources and fc event vector
    input  logic      dma_pe_evt_i,
    input  logic      dma_pe_irq_i,
    input  logic      pf_evt_i,
    output fc_event_t fc_events_o
);

    logic gpio_event;
    logic ref_rise;
    logic ref_fall;

    apb_if gpio_bus ();
    apb_if ctrl_bus ();

    //////////////////////////////////////////////////////////////////////
    // peripheral bus
    //////////////////////////////////////////////////////////////////////
    periph_bus_decoder i_decoder (
        .clk_i     ( clk_i         ),
        .rst_ni    ( rst_ni        ),
        .psel_i    ( apb_psel_i    ),
        .penable_i ( apb_penable_i ),
        .pwrite_i  ( apb_pwrite_i  ),
        .paddr_i   ( apb_paddr_i   ),
        .pwdata_i  ( apb_pwdata_i  ),
        .prdata_o  ( apb_prdata_o  ),
        .pready_o  ( apb_pready_o  ),
        .pslverr_o ( apb_pslverr_o ),
        .gpio_bus  ( gpio_bus      ),
        .ctrl_bus  ( ctrl_bus      )
    );

    gpio_regs i_gpio (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .bus          ( gpio_bus   ),
        .gpio_in_i    ( gpio_in_i  ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    soc_ctrl_regs i_soc_ctrl (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .bus            ( ctrl_bus       ),
        .soc_jtag_reg_i ( soc_jtag_reg_i ),
        .soc_jtag_reg_o ( soc_jtag_reg_o ),
        .fc_bootaddr_o  ( fc_bootaddr_o  ),
        .fc_fetchen_o   ( fc_fetchen_o   )
    );

    ref_clk_edge_detect i_ref_clk_sync (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( ref_rise   ),
        .fall_o     ( ref_fall   )
    );

    //////////////////////////////////////////////////////////////////////
    // fc event vector in the non-ibex layout
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        fc_events_o              = '0;         // sw events and dropped sources
        fc_events_o[EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[EVT_PF]      = pf_evt_i;
        fc_events_o[EVT_REF_CLK] = ref_rise | ref_fall; // both slow clk edges
        fc_events_o[EVT_GPIO]    = gpio_event;
    end

endmodule

/* verification/periph_checker.sv */
module periph_checker
    import periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    // dut apb, request and response
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pready_i,
    input  logic        pslverr_i,
    input  apb_data_t   prdata_i,
    // dut outputs
    input  gpio_vec_t   gpio_out_i,
    input  gpio_vec_t   gpio_dir_i,
    input  apb_data_t   bootaddr_i,
    input  logic        fetchen_i,
    input  jtag_reg_t   jtag_i,
    input  fc_event_t   events_i,
    // expected values from the testbench
    input  gpio_vec_t   exp_out_i,
    input  gpio_vec_t   exp_dir_i,
    input  apb_data_t   exp_bootaddr_i,
    input  logic        exp_fetchen_i,
    input  jtag_reg_t   exp_jtag_i,
    input  fc_event_t   exp_events_i,
    input  logic        exp_err_i,
    input  logic        chk_rdata_i,   // prdata only compared when set
    input  apb_data_t   exp_rdata_i,
    output int unsigned err_cnt_o
);

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got %08h expected %08h at %0t", name, got, expected, $time);
            err_cnt_o++;
        end
    endtask

    initial err_cnt_o = 0;

    // sampled on the rising edge, inputs moved half a cycle earlier
    always @(posedge clk_i) begin
        if (rst_ni) begin
            compare_value("gpio_out_o", gpio_out_i, exp_out_i);
            compare_value("gpio_dir_o", gpio_dir_i, exp_dir_i);
            compare_value("fc_bootaddr_o", bootaddr_i, exp_bootaddr_i);
            compare_value("fc_fetchen_o", fetchen_i, exp_fetchen_i);
            compare_value("soc_jtag_reg_o", jtag_i, exp_jtag_i);
            compare_value("fc_events_o", events_i, exp_events_i); // every bit, every cycle
            if (psel_i && penable_i && pready_i) begin      // completing access
                compare_value("apb_pslverr_o", pslverr_i, exp_err_i);
                if (chk_rdata_i)
                    compare_value("apb_prdata_o", prdata_i, exp_rdata_i);
            end
        end
    end

endmodule

/* verification/tb_soc_periph.sv */
module tb_soc_periph
    import periph_pkg::*;
();

    localparam int unsigned TIMEOUT = 64;            // cycles per wait loop
    localparam apb_addr_t   BASE    = 32'h1A10_0000; // peripheral window

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      slow_clk_i;
    logic      apb_psel_i, apb_penable_i, apb_pwrite_i;
    apb_addr_t apb_paddr_i;
    apb_data_t apb_pwdata_i, apb_prdata_o, fc_bootaddr_o;
    logic      apb_pready_o, apb_pslverr_o, fc_fetchen_o;
    gpio_vec_t gpio_in_i, gpio_out_o, gpio_dir_o;
    jtag_reg_t soc_jtag_reg_i, soc_jtag_reg_o;
    logic      dma_pe_evt_i, dma_pe_irq_i, pf_evt_i;
    fc_event_t fc_events_o;

    // expected state, moved on the falling edge after the dut
    gpio_vec_t  exp_out, exp_dir, exp_inten;
    apb_data_t  exp_bootaddr, exp_rdata;
    logic       exp_fetchen, exp_err, chk_rdata;
    jtag_reg_t  exp_jtag;
    fc_event_t  exp_events;
    logic       slow_prev;
    gpio_vec_t  gpio_prev;
    logic [2:0] ref_pipe, gpio_pipe;  // 3 edge latency lines
    apb_addr_t  bad_addr [4];
    apb_data_t  rd, pattern, mask;
    int unsigned n, tries, err_cnt, err_at_start = 0, tests_ok = 0, tests_bad = 0;
    int          seed;
    bit          timed_out = 1'b0;

    always #4 clk_i = ~clk_i;

    soc_periph_top soc_periph_top_inst (.*);

    periph_checker periph_checker_inst (
        .clk_i      ( clk_i         ), .rst_ni         ( rst_ni        ),
        .psel_i     ( apb_psel_i    ), .penable_i      ( apb_penable_i ),
        .pready_i   ( apb_pready_o  ), .pslverr_i      ( apb_pslverr_o ),
        .prdata_i   ( apb_prdata_o  ), .gpio_out_i     ( gpio_out_o    ),
        .gpio_dir_i ( gpio_dir_o    ), .bootaddr_i     ( fc_bootaddr_o ),
        .fetchen_i  ( fc_fetchen_o  ), .jtag_i         ( soc_jtag_reg_o ),
        .events_i   ( fc_events_o   ), .exp_out_i      ( exp_out       ),
        .exp_dir_i  ( exp_dir       ), .exp_bootaddr_i ( exp_bootaddr  ),
        .exp_fetchen_i ( exp_fetchen ), .exp_jtag_i    ( exp_jtag      ),
        .exp_events_i  ( exp_events  ), .exp_err_i     ( exp_err       ),
        .chk_rdata_i   ( chk_rdata   ), .exp_rdata_i   ( exp_rdata     ),
        .err_cnt_o     ( err_cnt     )
    );

    //////////////////////////////////////////////////////////////////////
    // reference model of the event vector
    //////////////////////////////////////////////////////////////////////
    function automatic fc_event_t ref_fc_events(input logic dma_pe, input logic dma_irq,
                                                input logic pf, input logic ref_edge,
                                                input logic gpio_edge);
        fc_event_t ev;
        ev              = '0;   // dropped sources stay low
        ev[EVT_DMA_PE]  = dma_pe;
        ev[EVT_DMA_IRQ] = dma_irq;
        ev[EVT_PF]      = pf;
        ev[EVT_REF_CLK] = ref_edge;
        ev[EVT_GPIO]    = gpio_edge;
        return ev;
    endfunction

    // toggles and masked rises, seen 3 edges later
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slow_prev <= 1'b0;
            gpio_prev <= '0;
            ref_pipe  <= '0;
            gpio_pipe <= '0;
        end else begin
            slow_prev <= slow_clk_i;
            gpio_prev <= gpio_in_i;
            ref_pipe  <= {ref_pipe[1:0], slow_clk_i ^ slow_prev};
            gpio_pipe <= {gpio_pipe[1:0], |(gpio_in_i & ~gpio_prev & exp_inten)};
        end
    end

    assign exp_events = ref_fc_events(dma_pe_evt_i, dma_pe_irq_i, pf_evt_i,
                                      ref_pipe[2], gpio_pipe[2]);

    //////////////////////////////////////////////////////////////////////
    // apb driver and helpers
    //////////////////////////////////////////////////////////////////////
    function automatic apb_addr_t addr_of(input slot_t slot, input reg_off_t off);
        return BASE | (apb_addr_t'(slot) << SLOT_LSB) | apb_addr_t'(off);
    endfunction

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
        @(negedge clk_i);
        apb_psel_i   = 1'b1;  // setup phase
        apb_pwrite_i = wr;
        apb_paddr_i  = addr;
        apb_pwdata_i = wdata;
        @(negedge clk_i);
        apb_penable_i = 1'b1; // access phase
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!apb_pready_o && n < TIMEOUT);
        if (!apb_pready_o) stop_on_timeout("apb access never saw pready");
        rd = apb_prdata_o;
        @(negedge clk_i);
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t expected, input logic check);
        chk_rdata = check;
        exp_rdata = expected;
        apb_xfer(1'b0, addr, '0);
        chk_rdata = 1'b0;
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles) @(negedge clk_i);
    endtask

    task automatic wait_event(input int unsigned idx);
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!fc_events_o[idx] && n < TIMEOUT);
        if (!fc_events_o[idx]) stop_on_timeout("expected event pulse never came");
        @(negedge clk_i);
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_at_start) begin
            tests_ok++;
            $display("test %-10s ok", name);
        end else begin
            tests_bad++;
            $display("test %-10s %0d mismatches", name, err_cnt - err_at_start);
        end
        err_at_start = err_cnt;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        timed_out = 1'b1;
        finish_run();
    endtask

    task automatic finish_run();
        $display("tests passed %0d failed %0d, mismatches %0d", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed           = 32'h38dea5a3;
        rst_ni         = 1'b0;
        slow_clk_i     = 1'b0;
        apb_psel_i     = 1'b0;
        apb_penable_i  = 1'b0;
        apb_pwrite_i   = 1'b0;
        apb_paddr_i    = '0;
        apb_pwdata_i   = '0;
        gpio_in_i      = '0;
        soc_jtag_reg_i = '0;
        dma_pe_evt_i   = 1'b0;
        dma_pe_irq_i   = 1'b0;
        pf_evt_i       = 1'b0;
        exp_out        = '0;
        exp_dir        = '0;
        exp_inten      = '0;
        exp_bootaddr   = BOOT_ADDR_RST;
        exp_fetchen    = 1'b0;
        exp_jtag       = '0;
        exp_err        = 1'b0;
        exp_rdata      = '0;
        chk_rdata      = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        idle(4);  // reset values checked every cycle
        end_test("reset");

        pattern = $random(seed);
        apb_write(addr_of(SLOT_GPIO, GPIO_DIR_OFF), pattern);
        exp_dir = pattern;
        apb_read(addr_of(SLOT_GPIO, GPIO_DIR_OFF), pattern, 1'b1);
        pattern = $random(seed);
        apb_write(addr_of(SLOT_GPIO, GPIO_OUT_OFF), pattern);
        exp_out = pattern;
        apb_read(addr_of(SLOT_GPIO, GPIO_OUT_OFF), pattern, 1'b1);
        pattern = $random(seed);
        apb_write(addr_of(SLOT_SOC_CTRL, CTRL_BOOTADDR_OFF), pattern);
        exp_bootaddr = pattern;
        apb_read(addr_of(SLOT_SOC_CTRL, CTRL_BOOTADDR_OFF), pattern, 1'b1);
        pattern = $random(seed);
        apb_write(addr_of(SLOT_SOC_CTRL, CTRL_FETCHEN_OFF), pattern);
        exp_fetchen = pattern[0];  // single bit register
        apb_read(addr_of(SLOT_SOC_CTRL, CTRL_FETCHEN_OFF), apb_data_t'(pattern[0]), 1'b1);
        soc_jtag_reg_i = jtag_reg_t'($random(seed));
        pattern = $random(seed);
        apb_write(addr_of(SLOT_SOC_CTRL, CTRL_JTAG_OFF), pattern);
        exp_jtag = pattern[JTAG_REG_W-1:0];
        apb_read(addr_of(SLOT_SOC_CTRL, CTRL_JTAG_OFF),
                 apb_data_t'({soc_jtag_reg_i, pattern[JTAG_REG_W-1:0]}), 1'b1);
        end_test("regs");

        pattern   = $random(seed);
        gpio_in_i = pattern;
        tries     = 0;
        do begin  // poll until the synchronizer catches up
            apb_read(addr_of(SLOT_GPIO, GPIO_IN_OFF), '0, 1'b0);
            tries++;
        end while (rd !== pattern && tries < TIMEOUT);
        if (rd !== pattern) stop_on_timeout("IN register never matched the pins");
        apb_read(addr_of(SLOT_GPIO, GPIO_IN_OFF), pattern, 1'b1);
        end_test("gpio_in");

        mask = $random(seed);
        apb_write(addr_of(SLOT_GPIO, GPIO_INTEN_OFF), mask);
        exp_inten = mask;
        repeat (3) begin
            gpio_in_i = '0;  // falling pins raise nothing
            idle(4);
            pattern   = $random(seed);
            gpio_in_i = pattern;
            if (|(pattern & mask)) wait_event(EVT_GPIO);
            idle(4);
            apb_read(addr_of(SLOT_GPIO, GPIO_INTSTAT_OFF), pattern & mask, 1'b1);
            apb_read(addr_of(SLOT_GPIO, GPIO_INTSTAT_OFF), '0, 1'b1); // cleared by read
        end
        end_test("gpio_irq");

        repeat (4) begin
            slow_clk_i = ~slow_clk_i;
            wait_event(EVT_REF_CLK);
            idle(2);
        end
        repeat (24) begin  // random strobes mixed with slow clock toggles
            pattern      = $random(seed);
            dma_pe_evt_i = pattern[0];
            dma_pe_irq_i = pattern[1];
            pf_evt_i     = pattern[2];
            if (pattern[3]) slow_clk_i = ~slow_clk_i;
            @(negedge clk_i);
        end
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        idle(4);
        end_test("events");

        bad_addr = '{addr_of(4'd7, 12'h000), addr_of(4'd0, 12'h004),
                     addr_of(SLOT_GPIO, 12'h014), addr_of(SLOT_SOC_CTRL, 12'h000)};
        exp_err = 1'b1;
        foreach (bad_addr[i]) begin
            chk_rdata = 1'b1;
            exp_rdata = '0;
            apb_write(bad_addr[i], $random(seed));
            apb_read(bad_addr[i], '0, 1'b1);
        end
        exp_err = 1'b0;
        idle(2);
        end_test("errors");

        finish_run();
    end

endmodule

/* files.f */
src/periph_pkg.sv
src/apb_if.sv
src/periph_bus_decoder.sv
src/gpio_regs.sv
src/soc_ctrl_regs.sv
src/ref_clk_edge_detect.sv
src/soc_periph_top.sv
verification/periph_checker.sv
verification/tb_soc_periph.sv

/* Bender.yml */
package:
  name: soc_periph

sources:
  # synthesizable design, package first
  - target: rtl
    files:
      - src/periph_pkg.sv
      - src/apb_if.sv
      - src/periph_bus_decoder.sv
      - src/gpio_regs.sv
      - src/soc_ctrl_regs.sv
      - src/ref_clk_edge_detect.sv
      - src/soc_periph_top.sv

  # testbench
  - target: test
    files:
      - verification/periph_checker.sv
      - verification/tb_soc_periph.sv
